//--- Bender.yml
package:
  name: mul_unit

sources:
  # packages before the interface and the modules that import them
  - design/mul_isa_pkg.sv
  - design/mul_unit_pkg.sv
  - design/mul_operand_if.sv
  - design/mul_array_core.sv
  - design/mul_unit_ctrl.sv
  - design/mul_unit_top.sv

  # testbench, top module mul_unit_tb
  - target: test
    files:
      - verification/mul_unit_tb.sv

//--- design/mul_array_core.sv
`timescale 1ns/10ps

module mul_array_core
    import mul_unit_pkg::*;
#(
    parameter int unsigned XLEN        = XLEN_DEFAULT,
    parameter int unsigned CORE_STAGES = STAGES_DEFAULT
) (
    input logic         clk,
    input logic         rst_n,
    mul_operand_if.core ops
);

    // operands widened by one bit, the extra bit follows the sign flag
    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN+1:0] full_product;
    logic [2*XLEN-1:0]        mult_lo;

    // payload pipeline and its valid chain
    logic [2*XLEN-1:0]        pipe [CORE_STAGES];
    logic [CORE_STAGES-1:0]   vld;

    assign a_ext = {ops.a_signed & ops.a[XLEN-1], ops.a};
    assign b_ext = {ops.b_signed & ops.b[XLEN-1], ops.b};

    // one signed multiply covers all four sign combinations
    assign full_product = a_ext * b_ext;

    // the top two bits only repeat the sign, the low 2*XLEN bits are the answer
    assign mult_lo = full_product[2*XLEN-1:0];

    // first stage captures on start, later stages move with their valid bit
    always_ff @(posedge clk) begin
        if (ops.start) begin
            pipe[0] <= mult_lo;
        end
        for (int i = 1; i < CORE_STAGES; i++) begin
            if (vld[i-1]) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // valid chain, several items may be in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld <= '0;
        end else if (ops.flush) begin
            // drop everything in flight
            vld <= '0;
        end else begin
            vld[0] <= ops.start;
            for (int i = 1; i < CORE_STAGES; i++) begin
                vld[i] <= vld[i-1];
            end
        end
    end

    // an item reaching the end in the flush cycle is discarded as well
    assign ops.done    = vld[CORE_STAGES-1] & ~ops.flush;
    assign ops.product = pipe[CORE_STAGES-1];

endmodule

//--- design/mul_isa_pkg.sv
package mul_isa_pkg;

    // width of an architectural register index
    localparam int unsigned REG_ADDR_W = 5;

    // rv32m multiply group, encoded as funct3[1:0]
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_op_e;

    // rs1, rs2 and rd index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

//--- design/mul_operand_if.sv
`timescale 1ns/10ps

interface mul_operand_if
    import mul_unit_pkg::*;
#(
    parameter int unsigned XLEN = XLEN_DEFAULT
) ();

    // request side, owned by the controller
    logic            start;
    logic            flush;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            a_signed;
    logic            b_signed;

    // completion side, owned by the core
    logic              done;
    logic [2*XLEN-1:0] product;

    modport ctrl (
        output start,
        output flush,
        output a,
        output b,
        output a_signed,
        output b_signed,
        input  done,
        input  product
    );

    modport core (
        input  start,
        input  flush,
        input  a,
        input  b,
        input  a_signed,
        input  b_signed,
        output done,
        output product
    );

endinterface

//--- design/mul_unit_ctrl.sv
`timescale 1ns/10ps

module mul_unit_ctrl
    import mul_isa_pkg::*;
    import mul_unit_pkg::*;
#(
    parameter int unsigned XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cancel,
    input  logic            req_valid,
    output logic            req_ready,
    output logic            rsp_valid,
    input  logic            rsp_ready,
    input  mul_op_e         op,
    input  reg_addr_t       rs1,
    input  reg_addr_t       rs2,
    input  reg_addr_t       rd,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    mul_operand_if.ctrl     core
);

    mul_state_e state_q;
    mul_state_e state_d;

    // decoded request
    logic dec_a_signed;
    logic dec_b_signed;
    logic dec_hi;

    // latched request
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;
    logic            a_signed_q;
    logic            b_signed_q;
    logic            hi_q;

    // stored product and whether it belongs to the latched operands
    logic [2*XLEN-1:0] product_q;
    logic              prod_ok_q;

    logic start_q;
    logic flush_q;
    logic req_ok;
    logic rsp_ok;
    logic reuse;

    // opcode decode
    // MUL counts as signed x signed so it can share a product with MULH
    always_comb begin
        case (op)
            MUL: begin
                dec_a_signed = 1'b1;
                dec_b_signed = 1'b1;
                dec_hi       = 1'b0;
            end
            MULH: begin
                dec_a_signed = 1'b1;
                dec_b_signed = 1'b1;
                dec_hi       = 1'b1;
            end
            MULHSU: begin
                dec_a_signed = 1'b1;
                dec_b_signed = 1'b0;
                dec_hi       = 1'b1;
            end
            MULHU: begin
                dec_a_signed = 1'b0;
                dec_b_signed = 1'b0;
                dec_hi       = 1'b1;
            end
            default: begin
                dec_a_signed = 1'b0;
                dec_b_signed = 1'b0;
                dec_hi       = 1'b0;
            end
        endcase
    end

    assign req_ready = (state_q == IDLE);
    assign rsp_valid = (state_q == BACK);

    assign req_ok = req_valid & req_ready & ~cancel;
    assign rsp_ok = rsp_valid & rsp_ready;

    // same operands and signs, and rd must not clobber a source
    // prod_ok_q guards against a product lost to a cancel
    assign reuse = (a == a_q)
                && (b == b_q)
                && (dec_a_signed == a_signed_q)
                && (dec_b_signed == b_signed_q)
                && (rd != rs1)
                && (rd != rs2)
                && prod_ok_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        case (state_q)
            IDLE: begin
                if (req_ok && reuse) begin
                    state_d = BACK;
                end else if (req_ok) begin
                    state_d = BUSY;
                end else begin
                    state_d = IDLE;
                end
            end
            BUSY: begin
                // cancel wins over a done in the same cycle
                if (cancel) begin
                    state_d = IDLE;
                end else if (core.done) begin
                    state_d = BACK;
                end else begin
                    state_d = BUSY;
                end
            end
            BACK: begin
                state_d = rsp_ok ? IDLE : BACK;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // operand latch, updated on every accepted request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_q        <= '0;
            b_q        <= '0;
            a_signed_q <= 1'b0;
            b_signed_q <= 1'b0;
            hi_q       <= 1'b0;
        end else if (req_ok) begin
            a_q        <= a;
            b_q        <= b;
            a_signed_q <= dec_a_signed;
            b_signed_q <= dec_b_signed;
            hi_q       <= dec_hi;
        end
    end

    // core strobes, both single-cycle pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_q <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            start_q <= req_ok & ~reuse;
            flush_q <= (state_q == BUSY) & cancel;
        end
    end

    // full product, both halves kept for later reuse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            product_q <= '0;
            prod_ok_q <= 1'b1;
        end else if (state_q == BUSY && core.done) begin
            product_q <= core.product;
            prod_ok_q <= 1'b1;
        end else if (req_ok && !reuse) begin
            prod_ok_q <= 1'b0;
        end
    end

    assign core.start    = start_q;
    assign core.flush    = flush_q;
    assign core.a        = a_q;
    assign core.b        = b_q;
    assign core.a_signed = a_signed_q;
    assign core.b_signed = b_signed_q;

    // only changes on accept, so it holds through BACK
    assign result = hi_q ? product_q[2*XLEN-1:XLEN] : product_q[XLEN-1:0];

endmodule

//--- design/mul_unit_pkg.sv
package mul_unit_pkg;

    // default operand width, 32 or 64
    localparam int unsigned XLEN_DEFAULT = 32;

    // default number of register stages in the multiplier core
    localparam int unsigned STAGES_DEFAULT = 2;

    // controller states, one-hot
    // IDLE accepts a request, BUSY waits for the core, BACK holds the response
    typedef enum logic [2:0] {
        IDLE = 3'b001,
        BUSY = 3'b010,
        BACK = 3'b100
    } mul_state_e;

endpackage

//--- design/mul_unit_top.sv
`timescale 1ns/10ps

module mul_unit_top
    import mul_isa_pkg::*;
    import mul_unit_pkg::*;
#(
    parameter int unsigned XLEN        = XLEN_DEFAULT,
    parameter int unsigned CORE_STAGES = STAGES_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cancel,
    input  logic            req_valid,
    output logic            req_ready,
    input  mul_op_e         op,
    input  reg_addr_t       rs1,
    input  reg_addr_t       rs2,
    input  reg_addr_t       rd,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            rsp_valid,
    input  logic            rsp_ready,
    output logic [XLEN-1:0] result
);

    // controller to core link
    mul_operand_if #(
        .XLEN (XLEN)
    ) i_ops ();

    mul_unit_ctrl #(
        .XLEN (XLEN)
    ) i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cancel    (cancel),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .op        (op),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .a         (a),
        .b         (b),
        .result    (result),
        .core      (i_ops.ctrl)
    );

    mul_array_core #(
        .XLEN        (XLEN),
        .CORE_STAGES (CORE_STAGES)
    ) i_core (
        .clk   (clk),
        .rst_n (rst_n),
        .ops   (i_ops.core)
    );

endmodule

//--- list.f
design/mul_isa_pkg.sv
design/mul_unit_pkg.sv
design/mul_operand_if.sv
design/mul_array_core.sv
design/mul_unit_ctrl.sv
design/mul_unit_top.sv
verification/mul_unit_tb.sv

//--- verification/mul_unit_tb.sv
`timescale 1ns/10ps

module mul_unit_tb
    import mul_isa_pkg::*;
    import mul_unit_pkg::*;
();

    localparam int unsigned XLEN           = XLEN_DEFAULT;
    localparam int unsigned TIMEOUT_CYCLES = 6000;

    logic            clk;
    logic            rst_n;
    logic            cancel;
    logic            req_valid;
    logic            req_ready;
    mul_op_e         op;
    reg_addr_t       rs1;
    reg_addr_t       rs2;
    reg_addr_t       rd;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            rsp_valid;
    logic            rsp_ready;
    logic [XLEN-1:0] result;

    // expected response of the request in flight
    logic [XLEN-1:0] exp_result;
    logic            exp_reuse;

    // model of the operand latch and of the stored product
    logic [XLEN-1:0] last_a;
    logic [XLEN-1:0] last_b;
    logic [1:0]      last_signs;
    bit              have_product;

    logic [31:0] lfsr_q    = 32'hd8b3d4dc;
    int unsigned cycle_cnt = 0;
    int          errors;
    int          txn_count;
    int          test_count;
    mul_state_e  stuck_state;

    mul_unit_top i_mul_unit_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cancel    (cancel),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .op        (op),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .a         (a),
        .b         (b),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stuck_state = i_mul_unit_top.i_ctrl.state_q;
            $display("timeout after %0d cycles, controller still in %s",
                     cycle_cnt, stuck_state.name());
            $display("Finished with errors");
            $finish;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v      = {v[30:0], lfsr_q[0]};
        end
        take_bits = v;
    endfunction

    // rv32m rules: rs1 signed for MULH and MULHSU, rs2 signed for MULH only
    function automatic logic [XLEN-1:0] ref_result(input mul_op_e op_i,
                                                   input logic [XLEN-1:0] a_i,
                                                   input logic [XLEN-1:0] b_i);
        logic [2*XLEN-1:0] ax;
        logic [2*XLEN-1:0] bx;
        logic [2*XLEN-1:0] prod;
        ax = {{XLEN{1'b0}}, a_i};
        bx = {{XLEN{1'b0}}, b_i};
        if (op_i == MULH || op_i == MULHSU) begin
            ax = {{XLEN{a_i[XLEN-1]}}, a_i};
        end
        if (op_i == MULH) begin
            bx = {{XLEN{b_i[XLEN-1]}}, b_i};
        end
        prod       = ax * bx;
        ref_result = (op_i == MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    endfunction

    // sign flags used for product reuse, MUL shares the signed x signed product
    function automatic logic [1:0] op_signs(input mul_op_e op_i);
        case (op_i)
            MUL, MULH: op_signs = 2'b11;
            MULHSU:    op_signs = 2'b10;
            default:   op_signs = 2'b00;
        endcase
    endfunction

    a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> (req_ready && !rsp_valid))
        else begin
            errors++;
            $display("after reset req_ready is not high or rsp_valid is not low");
        end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
                               rsp_valid |-> (result == exp_result))
        else begin
            errors++;
            $display("MISMATCH result got %h expected %h", $sampled(result), $sampled(exp_result));
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
                             (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(result)))
        else begin
            errors++;
            $display("response did not hold while rsp_ready was low");
        end

    a_no_req_in_back: assert property (@(posedge clk) disable iff (!rst_n)
                                       rsp_valid |-> !req_ready)
        else begin
            errors++;
            $display("req_ready was high while a response was pending");
        end

    a_reuse_latency: assert property (@(posedge clk) disable iff (!rst_n || cancel)
                                      (req_valid && req_ready && !cancel && exp_reuse)
                                      |=> rsp_valid)
        else begin
            errors++;
            $display("reused product did not come back one cycle after acceptance");
        end

    a_full_latency: assert property (@(posedge clk) disable iff (!rst_n || cancel)
                                     (req_valid && req_ready && !cancel && !exp_reuse)
                                     |=> !rsp_valid [*3] ##1 rsp_valid)
        else begin
            errors++;
            $display("computed product did not come back four cycles after acceptance");
        end

    a_cancel_idle: assert property (@(posedge clk) disable iff (!rst_n)
                                    (cancel && !req_ready && !rsp_valid)
                                    |=> (req_ready && !rsp_valid))
        else begin
            errors++;
            $display("cancel while busy did not return to idle without a response");
        end

    a_cancel_blocks: assert property (@(posedge clk) disable iff (!rst_n)
                                      (req_valid && req_ready && cancel)
                                      |=> (req_ready && !rsp_valid))
        else begin
            errors++;
            $display("a request presented with cancel high was accepted");
        end

    // one request from drive to response, or to cancel while busy
    // a negative cancel_dly runs the request to its response
    task automatic do_request(input mul_op_e op_i, input logic [XLEN-1:0] a_i,
                              input logic [XLEN-1:0] b_i, input reg_addr_t rs1_i,
                              input reg_addr_t rs2_i, input reg_addr_t rd_i,
                              input bit bp_i, input int cancel_dly);
        logic [1:0] sg;
        bit         hit;
        bit         fin;
        sg  = op_signs(op_i);
        hit = have_product && (a_i == last_a) && (b_i == last_b) && (sg == last_signs)
              && (rd_i != rs1_i) && (rd_i != rs2_i);
        exp_result <= ref_result(op_i, a_i, b_i);
        exp_reuse  <= hit;
        req_valid  <= 1'b1;
        op         <= op_i;
        a          <= a_i;
        b          <= b_i;
        rs1        <= rs1_i;
        rs2        <= rs2_i;
        rd         <= rd_i;
        rsp_ready  <= bp_i ? (take_bits(1) != 0) : 1'b1;
        // wait for the accepting edge
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        req_valid  <= 1'b0;
        last_a     = a_i;
        last_b     = b_i;
        last_signs = sg;
        if (!hit) begin
            have_product = 0;
        end
        txn_count++;
        if (cancel_dly >= 0) begin
            repeat (cancel_dly) @(posedge clk);
            cancel <= 1'b1;
            @(posedge clk);
            cancel <= 1'b0;
            // a cancel on the done edge still stores the product
            if (cancel_dly == STAGES_DEFAULT) begin
                have_product = 1;
            end
        end else begin
            do begin
                @(posedge clk);
                fin = rsp_valid && rsp_ready;
                if (!fin && bp_i) begin
                    rsp_ready <= (take_bits(1) != 0);
                end
            end while (!fin);
            have_product = 1;
        end
    endtask

    // request held with cancel high, must not be taken
    task automatic present_with_cancel();
        req_valid <= 1'b1;
        cancel    <= 1'b1;
        op        <= mul_op_e'(take_bits(2));
        a         <= take_bits(XLEN);
        b         <= take_bits(XLEN);
        repeat (2) @(posedge clk);
        req_valid <= 1'b0;
        cancel    <= 1'b0;
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int err_before, input int txn_before);
        // let action blocks of the last edge land first
        @(posedge clk);
        test_count++;
        $display("test %-14s %4d transactions, %0d errors",
                 name, txn_count - txn_before, errors - err_before);
    endtask

    task automatic random_traffic(input string name, input int count, input bit bp_i);
        int              err_before;
        int              txn_before;
        logic [XLEN-1:0] a_v;
        logic [XLEN-1:0] b_v;
        err_before = errors;
        txn_before = txn_count;
        a_v        = take_bits(XLEN);
        b_v        = take_bits(XLEN);
        repeat (count) begin
            // a quarter of the requests repeat the previous operands
            if (take_bits(2) != 0) begin
                a_v = take_bits(XLEN);
                b_v = take_bits(XLEN);
            end
            do_request(mul_op_e'(take_bits(2)), a_v, b_v, reg_addr_t'(take_bits(5)),
                       reg_addr_t'(take_bits(5)), reg_addr_t'(take_bits(5)), bp_i, -1);
        end
        report_test(name, err_before, txn_before);
    endtask

    task automatic reuse_patterns();
        int              err_before;
        int              txn_before;
        logic [XLEN-1:0] a_v;
        logic [XLEN-1:0] b_v;
        err_before = errors;
        txn_before = txn_count;
        a_v        = take_bits(XLEN);
        b_v        = take_bits(XLEN);
        do_request(MULH,   a_v, b_v, 5'd1, 5'd2, 5'd3, 1'b0, -1);
        // low half from the stored signed product
        do_request(MUL,    a_v, b_v, 5'd1, 5'd2, 5'd3, 1'b0, -1);
        do_request(MULHSU, a_v, b_v, 5'd1, 5'd2, 5'd3, 1'b0, -1);
        // rd overwrites a source
        do_request(MULHSU, a_v, b_v, 5'd1, 5'd2, 5'd1, 1'b0, -1);
        do_request(MULHSU, a_v, b_v, 5'd1, 5'd2, 5'd2, 1'b0, -1);
        do_request(MULHSU, a_v, b_v, 5'd1, 5'd2, 5'd4, 1'b0, -1);
        do_request(MULHU, 32'h8000_0000, 32'hffff_ffff, 5'd7, 5'd8, 5'd9, 1'b0, -1);
        do_request(MULHU, 32'h8000_0000, 32'hffff_ffff, 5'd7, 5'd8, 5'd9, 1'b0, -1);
        do_request(MULH,  32'h8000_0000, 32'h8000_0000, 5'd7, 5'd8, 5'd9, 1'b0, -1);
        do_request(MUL,   32'h8000_0000, 32'h8000_0000, 5'd7, 5'd8, 5'd9, 1'b0, -1);
        report_test("reuse", err_before, txn_before);
    endtask

    task automatic cancel_cases();
        int              err_before;
        int              txn_before;
        logic [XLEN-1:0] a_v;
        logic [XLEN-1:0] b_v;
        mul_op_e         op_v;
        reg_addr_t       r;
        err_before = errors;
        txn_before = txn_count;
        // cancel points from the first busy cycle up to the done edge
        for (int i = 0; i < 9; i++) begin
            a_v  = take_bits(XLEN);
            b_v  = take_bits(XLEN);
            op_v = mul_op_e'(take_bits(2));
            r    = reg_addr_t'(take_bits(5));
            // rd equal to rs1 so the core is always started
            do_request(op_v, a_v, b_v, r, r + 5'd1, r, 1'b0, i % 3);
            // same operands right after the cancel, a stale done would end it early
            do_request(op_v, a_v, b_v, r, r + 5'd1, r + 5'd2, 1'b0, -1);
            present_with_cancel();
        end
        report_test("cancel", err_before, txn_before);
    endtask

    initial begin
        rst_n        = 1'b0;
        cancel       = 1'b0;
        req_valid    = 1'b0;
        op           = MUL;
        rs1          = '0;
        rs2          = '0;
        rd           = '0;
        a            = '0;
        b            = '0;
        rsp_ready    = 1'b0;
        exp_result   = '0;
        exp_reuse    = 1'b0;
        // latch contents right after reset
        last_a       = '0;
        last_b       = '0;
        last_signs   = 2'b00;
        have_product = 1;
        errors       = 0;
        txn_count    = 0;
        test_count   = 0;
        repeat (16) @(posedge clk);
        rst_n     <= 1'b1;
        rsp_ready <= 1'b1;
        repeat (2) @(posedge clk);
        report_test("reset", 0, 0);
        random_traffic("random", 120, 1'b0);
        reuse_patterns();
        random_traffic("backpressure", 40, 1'b1);
        cancel_cases();
        $display("%0d tests, %0d transactions, %0d errors", test_count, txn_count, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
